/* ifu_align.f */
+incdir+src
src/ifu_pkg.sv
src/ifu_compress_ctl.sv
src/ifu_fetch_buf.sv
src/ifu_issue_reg.sv
src/ifu_align_ctl.sv
src/ifu_align_top.sv
test/ifu_align_chk.sv
test/ifu_align_tb.sv

/* Makefile */
# Verilator build and run for the instruction aligner

VERILATOR ?= verilator
TOP       ?= ifu_align_tb
FILELIST  ?= ifu_align.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/ifu_align_tb.sv */
//****************************
// testbench for the instruction aligner
// packs a table of instructions into fetch words, sends them
// with random gaps and decoder stalls, then redirects to an odd
// halfword; a monitor checks each issued instruction in order
//****************************

`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_align_tb;

   import ifu_pkg::*;

   localparam int N_ENT = 28;
   localparam int LIMIT = (N_ENT + 3) * 20 + 200;

   // {compressed, illegal, raw instruction, expected expansion}
   localparam logic [65:0] TABLE [N_ENT] = '{
      {1'b1, 1'b0, 32'h0000_0405, 32'h0014_0413},   // c.addi x8,1
      {1'b1, 1'b0, 32'h0000_0001, 32'h0000_0013},   // c.nop
      {1'b1, 1'b0, 32'h0000_557d, 32'hfff0_0513},   // c.li x10,-1
      {1'b0, 1'b0, 32'h00a0_0093, 32'h00a0_0093},   // straddles two words
      {1'b1, 1'b0, 32'h0000_6585, 32'h0000_15b7},   // c.lui x11,1
      {1'b1, 1'b0, 32'h0000_6141, 32'h0101_0113},   // c.addi16sp 16
      {1'b1, 1'b0, 32'h0000_0040, 32'h0041_0413},   // c.addi4spn x8,4
      {1'b0, 1'b0, 32'h0020_81b3, 32'h0020_81b3},
      {1'b1, 1'b0, 32'h0000_4044, 32'h0044_2483},   // c.lw x9,4(x8)
      {1'b0, 1'b0, 32'hdead_c0b7, 32'hdead_c0b7},   // straddles two words
      {1'b1, 1'b0, 32'h0000_c404, 32'h0094_2423},   // c.sw x9,8(x8)
      {1'b1, 1'b1, 32'h0000_0000, 32'h0000_0000},   // all-zero halfword
      {1'b1, 1'b0, 32'h0000_a011, 32'h0040_006f},   // c.j +4
      {1'b1, 1'b0, 32'h0000_2021, 32'h0080_00ef},   // c.jal +8
      {1'b1, 1'b0, 32'h0000_c401, 32'h0004_0463},   // c.beqz x8,+8
      {1'b1, 1'b0, 32'h0000_e091, 32'h0004_9263},   // c.bnez x9,+4
      {1'b1, 1'b0, 32'h0000_8009, 32'h0024_5413},   // c.srli x8,2
      {1'b1, 1'b1, 32'h0000_2000, 32'h0000_0000},   // c.fld, not supported
      {1'b1, 1'b0, 32'h0000_8c05, 32'h4094_0433},   // c.sub x8,x9
      {1'b0, 1'b0, 32'h4020_8233, 32'h4020_8233},
      {1'b1, 1'b0, 32'h0000_050e, 32'h0035_1513},   // c.slli x10,3
      {1'b1, 1'b0, 32'h0000_45a2, 32'h0081_2583},   // c.lwsp x11,8
      {1'b1, 1'b0, 32'h0000_c632, 32'h00c1_2623},   // c.swsp x12,12
      {1'b1, 1'b1, 32'h0000_4002, 32'h0000_0000},   // c.lwsp to x0
      {1'b1, 1'b0, 32'h0000_86ba, 32'h00e0_06b3},   // c.mv x13,x14
      {1'b1, 1'b0, 32'h0000_96ba, 32'h00e6_86b3},   // c.add x13,x14
      {1'b1, 1'b0, 32'h0000_8082, 32'h0000_8067},   // c.jr x1
      {1'b1, 1'b0, 32'h0000_9002, 32'h0010_0073}    // c.ebreak
   };

   logic    clk;
   logic    reset;
   logic    fetch_valid;
   inst32_t fetch_data;
   logic    fetch_stall;
   logic    redirect;
   pc_t     redirect_pc;
   logic    dec_stall;
   logic    inst_valid;
   inst32_t inst_data;
   pc_t     inst_pc;
   logic    inst_compressed;
   logic    inst_illegal;

   inst32_t exp_data [$];
   pc_t     exp_pc [$];
   logic    exp_comp [$];
   logic    exp_ill [$];
   inst16_t hw_q [$];
   int      cycles;
   int      err_count;

   // halfwords written to and taken from the buffer since the last flush
   int      hw_pushed;
   int      hw_consumed;
   int      hw_held;
   logic    skip_low;

   ifu_align_top uut (
      .clk             (clk),
      .reset           (reset),
      .fetch_valid     (fetch_valid),
      .fetch_data      (fetch_data),
      .fetch_stall     (fetch_stall),
      .redirect        (redirect),
      .redirect_pc     (redirect_pc),
      .dec_stall       (dec_stall),
      .inst_valid      (inst_valid),
      .inst_data       (inst_data),
      .inst_pc         (inst_pc),
      .inst_compressed (inst_compressed),
      .inst_illegal    (inst_illegal)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //****************************
   // failure reporting and compares
   //****************************

   task automatic report_failure();
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_inst(input inst32_t exp, input inst32_t act);
      if (exp !== act) begin
         err_count++;
         $display("[FAIL] inst_data expected %08h actual %08h", exp, act);
         report_failure();
      end
   endtask

   task automatic check_pc(input pc_t exp, input pc_t act);
      if (exp !== act) begin
         err_count++;
         $display("[FAIL] inst_pc expected %08h actual %08h", exp, act);
         report_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         err_count++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic expect_inst(input inst32_t data, input pc_t pc, input logic comp,
                              input logic ill);
      exp_data.push_back(data);
      exp_pc.push_back(pc);
      exp_comp.push_back(comp);
      exp_ill.push_back(ill);
   endtask

   // called 1 ns after an edge, returns at the same point
   task automatic send_word(input inst32_t w);
      while (fetch_stall || ($urandom % 3 == 0)) begin
         @(posedge clk);
         #1;
      end
      fetch_valid = 1'b1;
      fetch_data  = w;
      @(posedge clk);
      // a word after an odd redirect only brings its upper halfword
      hw_pushed = hw_pushed + (skip_low ? 1 : 2);
      skip_low  = 1'b0;
      #1;
      fetch_valid = 1'b0;
   endtask

   //****************************
   // monitor and timeout
   //****************************

   always @(posedge clk) begin
      if (!reset && inst_valid && !dec_stall) begin
         if (exp_data.size() == 0) begin
            $display("an instruction was issued that was not expected");
            report_failure();
         end else begin
            check_inst(exp_data.pop_front(), inst_data);
            check_pc(exp_pc.pop_front(), inst_pc);
            hw_consumed = hw_consumed + (exp_comp[0] ? 1 : 2);
            check_flag("inst_compressed", exp_comp.pop_front(), inst_compressed);
            check_flag("inst_illegal", exp_ill.pop_front(), inst_illegal);
         end
      end
   end

   // buffer holds what was pushed minus what was consumed or sits in issue
   always @(negedge clk) begin
      if (!reset && (!inst_valid || exp_comp.size() != 0)) begin
         hw_held = hw_pushed - hw_consumed;
         if (inst_valid) begin
            hw_held = hw_held - (exp_comp[0] ? 1 : 2);
         end
         check_flag("fetch_stall", hw_held > 2, fetch_stall);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout after %0d cycles with %0d instructions pending",
                  cycles, exp_data.size());
         report_failure();
      end
   end

   // random decoder stalls for the whole run
   initial begin
      @(negedge reset);
      forever begin
         @(posedge clk);
         #1;
         dec_stall = ($urandom % 4 == 0);
      end
   end

   //****************************
   // main sequence
   //****************************

   initial begin
      pc_t pc;
      int  i;

      void'($urandom(32'hbac6));
      cycles      = 0;
      err_count   = 0;
      hw_pushed   = 0;
      hw_consumed = 0;
      hw_held     = 0;
      skip_low    = 1'b0;
      reset       = 1'b1;
      fetch_valid = 1'b0;
      fetch_data  = '0;
      redirect    = 1'b0;
      redirect_pc = '0;
      dec_stall   = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;

      // build the halfword stream and the expected records
      pc = pc_t'(`IFU_RESET_PC);
      for (i = 0; i < N_ENT; i++) begin
         expect_inst(TABLE[i][31:0], pc, TABLE[i][65], TABLE[i][64]);
         hw_q.push_back(TABLE[i][47:32]);
         if (TABLE[i][65]) begin
            pc = pc + 2;
         end else begin
            hw_q.push_back(TABLE[i][63:48]);
            pc = pc + 4;
         end
      end
      // pad with c.nop to fill the last word
      if (hw_q.size() % 2 != 0) begin
         hw_q.push_back(16'h0001);
         expect_inst(32'h0000_0013, pc, 1'b1, 1'b0);
      end

      while (hw_q.size() != 0) begin
         send_word({hw_q[1], hw_q[0]});
         void'(hw_q.pop_front());
         void'(hw_q.pop_front());
      end

      // drain before redirecting
      while (exp_data.size() != 0 || inst_valid) begin
         @(posedge clk);
         #1;
      end

      // redirect to an odd halfword, lower half of next word is junk
      redirect    = 1'b1;
      redirect_pc = 32'h0000_0102;
      @(posedge clk);
      #1;
      redirect = 1'b0;
      // flush empties the buffer and the issue register
      hw_pushed   = 0;
      hw_consumed = 0;
      skip_low    = redirect_pc[1];
      expect_inst(32'h0014_0413, 32'h0000_0102, 1'b1, 1'b0);
      expect_inst(32'hfff0_0513, 32'h0000_0104, 1'b1, 1'b0);
      expect_inst(32'h0000_0013, 32'h0000_0106, 1'b1, 1'b0);
      send_word({16'h0405, 16'hdead});
      send_word({16'h0001, 16'h557d});

      while (exp_data.size() != 0) begin
         @(posedge clk);
         #1;
      end
      repeat (4) @(posedge clk);

      if (err_count == 0 && exp_data.size() == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         report_failure();
      end
   end

endmodule

`default_nettype wire

/* test/ifu_align_chk.sv */
//****************************
// protocol assertions for the instruction aligner
// bound onto the top level, watches only its ports
//****************************

`timescale 1ns/1ps
`default_nettype none

module ifu_align_chk (
   input logic             clk,
   input logic             reset,
   input logic             fetch_valid,
   input logic             fetch_stall,
   input logic             redirect,
   input logic             dec_stall,
   input logic             inst_valid,
   input ifu_pkg::inst32_t inst_data,
   input ifu_pkg::pc_t     inst_pc,
   input logic             inst_compressed,
   input logic             inst_illegal
);

   import ifu_pkg::*;

   a_no_fetch_in_stall: assert property (@(posedge clk) disable iff (reset)
      fetch_valid |-> !fetch_stall)
      else $error("fetch strobe while fetch_stall high");

   // a redirect is allowed to drop a held instruction
   a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      (inst_valid && dec_stall && !redirect) |=>
         (inst_valid && $stable(inst_data) && $stable(inst_pc) &&
          $stable(inst_compressed) && $stable(inst_illegal)))
      else $error("issue outputs changed under dec_stall");

   a_illegal_zero: assert property (@(posedge clk) disable iff (reset)
      (inst_valid && inst_illegal) |-> (inst_data == '0))
      else $error("illegal instruction with nonzero data");

   a_redirect_clears: assert property (@(posedge clk) disable iff (reset)
      redirect |=> !inst_valid)
      else $error("inst_valid high after redirect");

endmodule

bind ifu_align_top ifu_align_chk u_chk (
   .clk             (clk),
   .reset           (reset),
   .fetch_valid     (fetch_valid),
   .fetch_stall     (fetch_stall),
   .redirect        (redirect),
   .dec_stall       (dec_stall),
   .inst_valid      (inst_valid),
   .inst_data       (inst_data),
   .inst_pc         (inst_pc),
   .inst_compressed (inst_compressed),
   .inst_illegal    (inst_illegal)
);

`default_nettype wire

/* src/ifu_align_top.sv */
//****************************
// instruction aligner top level
// fetch words in, aligned and expanded instructions out
// connects the buffer, control, expander and issue register
//****************************

`timescale 1ns/1ps
`default_nettype none

module ifu_align_top (
   input  logic             clk,
   input  logic             reset,
   input  logic             fetch_valid,
   input  ifu_pkg::inst32_t fetch_data,
   output logic             fetch_stall,
   input  logic             redirect,
   input  ifu_pkg::pc_t     redirect_pc,
   input  logic             dec_stall,
   output logic             inst_valid,
   output ifu_pkg::inst32_t inst_data,
   output ifu_pkg::pc_t     inst_pc,
   output logic             inst_compressed,
   output logic             inst_illegal
);

   import ifu_pkg::*;

   inst16_t head_hw0;
   inst16_t head_hw1;
   hw_cnt_t hw_count;
   inst32_t expanded;
   logic    legal;
   logic    push;
   logic    drop_first;
   logic    pop_one;
   logic    pop_two;
   logic    flush;
   logic    load;
   logic    is_compressed;
   logic    issue_busy;

   ifu_fetch_buf u_fetch_buf (
      .clk        (clk),
      .reset      (reset),
      .push       (push),
      .fetch_data (fetch_data),
      .drop_first (drop_first),
      .pop_one    (pop_one),
      .pop_two    (pop_two),
      .flush      (flush),
      .head_hw0   (head_hw0),
      .head_hw1   (head_hw1),
      .hw_count   (hw_count)
   );

   ifu_align_ctl u_align_ctl (
      .clk           (clk),
      .reset         (reset),
      .fetch_valid   (fetch_valid),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc),
      .head_hw0      (head_hw0),
      .head_hw1      (head_hw1),
      .hw_count      (hw_count),
      .issue_busy    (issue_busy),
      .push          (push),
      .drop_first    (drop_first),
      .pop_one       (pop_one),
      .pop_two       (pop_two),
      .flush         (flush),
      .load          (load),
      .is_compressed (is_compressed),
      .fetch_stall   (fetch_stall)
   );

   ifu_compress_ctl u_compress_ctl (
      .din   (head_hw0),
      .dout  (expanded),
      .legal (legal)
   );

   ifu_issue_reg u_issue_reg (
      .clk             (clk),
      .reset           (reset),
      .load            (load),
      .flush           (flush),
      .redirect_pc     (redirect_pc),
      .is_compressed   (is_compressed),
      .expanded        (expanded),
      .legal           (legal),
      .head_hw0        (head_hw0),
      .head_hw1        (head_hw1),
      .dec_stall       (dec_stall),
      .inst_valid      (inst_valid),
      .inst_data       (inst_data),
      .inst_pc         (inst_pc),
      .inst_compressed (inst_compressed),
      .inst_illegal    (inst_illegal),
      .issue_busy      (issue_busy)
   );

endmodule

`default_nettype wire

/* src/ifu_align_ctl.sv */
//****************************
// aligner control
// finds instruction length at the buffer head, pops and loads
// the issue register, throttles fetch and handles redirects
//****************************

`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_align_ctl (
   input  logic             clk,
   input  logic             reset,
   input  logic             fetch_valid,
   input  logic             redirect,
   input  ifu_pkg::pc_t     redirect_pc,
   input  ifu_pkg::inst16_t head_hw0,
   input  ifu_pkg::inst16_t head_hw1,
   input  ifu_pkg::hw_cnt_t hw_count,
   input  logic             issue_busy,
   output logic             push,
   output logic             drop_first,
   output logic             pop_one,
   output logic             pop_two,
   output logic             flush,
   output logic             load,
   output logic             is_compressed,
   output logic             fetch_stall
);

   import ifu_pkg::*;

   align_state_e state;
   logic         head_ready;
   logic         head_hw1_ok;

   //****************************
   // skip state after an odd redirect
   //****************************

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ALIGN_RUN;
      end else if (redirect) begin
         state <= redirect_pc[1] ? ALIGN_SKIP : ALIGN_RUN;
      end else if (push) begin
         state <= ALIGN_RUN;
      end
   end

   assign flush      = redirect;
   assign push       = fetch_valid & ~redirect;
   assign drop_first = (state == ALIGN_SKIP);

   //****************************
   // length decode and issue
   //****************************

   assign is_compressed = (head_hw0[1:0] != 2'b11);

   // upper half of a 32-bit head is only meaningful with two halfwords queued
   assign head_hw1_ok = (hw_count >= hw_cnt_t'(2));

   assign head_ready = (is_compressed && hw_count >= hw_cnt_t'(1)) ||
                       (!is_compressed && head_hw1_ok);

   assign load    = ~redirect & ~issue_busy & head_ready;
   assign pop_one = load & is_compressed;
   assign pop_two = load & ~is_compressed;

   // leave room for a full fetch word
   assign fetch_stall = (hw_count > hw_cnt_t'(`IFU_BUF_HW - 2));

endmodule

`default_nettype wire

/* src/ifu_issue_reg.sv */
//****************************
// issue register and next-PC counter
// captures the aligned instruction with its PC and flags
// and holds them while the decoder stalls
//****************************

`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_issue_reg (
   input  logic             clk,
   input  logic             reset,
   input  logic             load,
   input  logic             flush,
   input  ifu_pkg::pc_t     redirect_pc,
   input  logic             is_compressed,
   input  ifu_pkg::inst32_t expanded,
   input  logic             legal,
   input  ifu_pkg::inst16_t head_hw0,
   input  ifu_pkg::inst16_t head_hw1,
   input  logic             dec_stall,
   output logic             inst_valid,
   output ifu_pkg::inst32_t inst_data,
   output ifu_pkg::pc_t     inst_pc,
   output logic             inst_compressed,
   output logic             inst_illegal,
   output logic             issue_busy
);

   import ifu_pkg::*;

   pc_t     next_pc;
   inst32_t sel_data;

   // expanded form for a compressed head, raw halfwords otherwise
   assign sel_data   = is_compressed ? expanded : {head_hw1, head_hw0};
   assign issue_busy = inst_valid & dec_stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         next_pc <= pc_t'(`IFU_RESET_PC);
      end else if (flush) begin
         next_pc <= redirect_pc;
      end else if (load) begin
         next_pc <= next_pc + (is_compressed ? pc_t'(2) : pc_t'(4));
      end
   end

   // valid drops once consumed unless a new one loads
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         inst_valid      <= 1'b0;
         inst_compressed <= 1'b0;
         inst_illegal    <= 1'b0;
      end else if (load) begin
         inst_valid      <= 1'b1;
         inst_compressed <= is_compressed;
         inst_illegal    <= is_compressed & ~legal;
      end else if (!dec_stall) begin
         inst_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         inst_data <= sel_data;
         inst_pc   <= next_pc;
      end
   end

endmodule

`default_nettype wire

/* src/ifu_fetch_buf.sv */
//****************************
// halfword queue between fetch and the aligner
// a fetch word writes two halfwords, or only its upper one
// after a redirect to an odd halfword, and the aligner pops
// one or two halfwords per cycle from the head
//****************************

`timescale 1ns/1ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_fetch_buf (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  ifu_pkg::inst32_t fetch_data,
   input  logic             drop_first,
   input  logic             pop_one,
   input  logic             pop_two,
   input  logic             flush,
   output ifu_pkg::inst16_t head_hw0,
   output ifu_pkg::inst16_t head_hw1,
   output ifu_pkg::hw_cnt_t hw_count
);

   import ifu_pkg::*;

   localparam int PTR_W = $clog2(`IFU_BUF_HW);

   inst16_t          mem [`IFU_BUF_HW];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr_p1;
   logic [PTR_W-1:0] wr_ptr_p1;
   hw_cnt_t          count;
   hw_cnt_t          push_n;
   hw_cnt_t          pop_n;

   assign rd_ptr_p1 = rd_ptr + 1'b1;
   assign wr_ptr_p1 = wr_ptr + 1'b1;

   // halfwords entering and leaving this cycle
   assign push_n = !push ? hw_cnt_t'(0) : (drop_first ? hw_cnt_t'(1) : hw_cnt_t'(2));
   assign pop_n  = pop_two ? hw_cnt_t'(2) : (pop_one ? hw_cnt_t'(1) : hw_cnt_t'(0));

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         if (drop_first) begin
            mem[wr_ptr] <= fetch_data[31:16];
         end else begin
            mem[wr_ptr]    <= fetch_data[15:0];
            mem[wr_ptr_p1] <= fetch_data[31:16];
         end
      end
   end

   // pointers wrap naturally since the depth is a power of two
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         rd_ptr <= rd_ptr + pop_n[PTR_W-1:0];
         wr_ptr <= wr_ptr + push_n[PTR_W-1:0];
         count  <= count + push_n - pop_n;
      end
   end

   assign head_hw0 = mem[rd_ptr];
   assign head_hw1 = mem[rd_ptr_p1];
   assign hw_count = count;

endmodule

`default_nettype wire

/* src/ifu_compress_ctl.sv */
//****************************
// RV32C expander
// turns a 16-bit compressed instruction into its 32-bit base form
// purely combinational, dout is zero and legal low for
// reserved or unsupported encodings
//****************************

`timescale 1ns/1ps
`default_nettype none

module ifu_compress_ctl (
   input  ifu_pkg::inst16_t din,
   output ifu_pkg::inst32_t dout,
   output logic             legal
);

   import ifu_pkg::*;

   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

   //****************************
   // base instruction formats
   //****************************

   function automatic inst32_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic inst32_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic inst32_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
   endfunction

   function automatic inst32_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic inst32_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   // register fields, primed ones map to x8..x15
   logic [4:0] rd;
   logic [4:0] rs2;
   logic [4:0] rdp;
   logic [4:0] rs2p;

   // immediates and offsets in their 32-bit positions
   logic [11:0] imm6;
   logic [11:0] imm_4spn;
   logic [11:0] imm_lw;
   logic [11:0] imm_lwsp;
   logic [11:0] imm_swsp;
   logic [11:0] imm_16sp;
   logic [19:0] imm_lui;
   logic [20:0] off_j;
   logic [12:0] off_b;

   inst32_t o;
   logic    ok;

   assign rd   = din[11:7];
   assign rs2  = din[6:2];
   assign rdp  = {2'b01, din[9:7]};
   assign rs2p = {2'b01, din[4:2]};

   assign imm6     = {{6{din[12]}}, din[12], din[6:2]};
   assign imm_4spn = {2'b00, din[10:7], din[12:11], din[5], din[6], 2'b00};
   assign imm_lw   = {5'b0, din[5], din[12:10], din[6], 2'b00};
   assign imm_lwsp = {4'b0, din[3:2], din[12], din[6:4], 2'b00};
   assign imm_swsp = {4'b0, din[8:7], din[12:9], 2'b00};
   assign imm_16sp = {{3{din[12]}}, din[4:3], din[5], din[2], din[6], 4'b0000};
   assign imm_lui  = {{15{din[12]}}, din[6:2]};
   assign off_j    = {{10{din[12]}}, din[8], din[10:9], din[6], din[7], din[2], din[11],
                      din[5:3], 1'b0};
   assign off_b    = {{5{din[12]}}, din[6:5], din[2], din[11:10], din[4:3], 1'b0};

   //****************************
   // decode by quadrant and funct3
   //****************************

   always_comb begin
      o  = '0;
      ok = 1'b1;
      case (din[1:0])
         2'b00: begin
            case (din[15:13])
               // c.addi4spn, zero immediate is reserved
               3'b000: begin
                  o  = enc_i(imm_4spn, 5'd2, 3'b000, rs2p, OP_IMM);
                  ok = (imm_4spn != '0);
               end
               3'b010: o = enc_i(imm_lw, rdp, 3'b010, rs2p, OP_LOAD);
               3'b110: o = enc_s(imm_lw, rs2p, rdp, 3'b010);
               // float forms and the reserved slot
               default: ok = 1'b0;
            endcase
         end
         2'b01: begin
            case (din[15:13])
               // c.addi and c.nop
               3'b000: o = enc_i(imm6, rd, 3'b000, rd, OP_IMM);
               3'b001: o = enc_j(off_j, 5'd1);
               // c.li
               3'b010: o = enc_i(imm6, 5'd0, 3'b000, rd, OP_IMM);
               3'b011: begin
                  if (rd == 5'd2) begin
                     // c.addi16sp
                     o  = enc_i(imm_16sp, 5'd2, 3'b000, 5'd2, OP_IMM);
                     ok = (imm_16sp != '0);
                  end else begin
                     o  = {imm_lui, rd, OP_LUI};
                     ok = (imm_lui != '0);
                  end
               end
               3'b100: begin
                  case (din[11:10])
                     // shamt[5] set is not valid on RV32
                     2'b00: begin
                        o  = enc_i({7'b0000000, rs2}, rdp, 3'b101, rdp, OP_IMM);
                        ok = ~din[12];
                     end
                     2'b01: begin
                        o  = enc_i({7'b0100000, rs2}, rdp, 3'b101, rdp, OP_IMM);
                        ok = ~din[12];
                     end
                     2'b10: o = enc_i(imm6, rdp, 3'b111, rdp, OP_IMM);
                     default: begin
                        // sub xor or and, din[12] set is RV64 only
                        ok = ~din[12];
                        case (din[6:5])
                           2'b00:   o = enc_r(7'b0100000, rs2p, rdp, 3'b000, rdp);
                           2'b01:   o = enc_r(7'b0000000, rs2p, rdp, 3'b100, rdp);
                           2'b10:   o = enc_r(7'b0000000, rs2p, rdp, 3'b110, rdp);
                           default: o = enc_r(7'b0000000, rs2p, rdp, 3'b111, rdp);
                        endcase
                     end
                  endcase
               end
               3'b101: o = enc_j(off_j, 5'd0);
               3'b110: o = enc_b(off_b, 5'd0, rdp, 3'b000);
               default: o = enc_b(off_b, 5'd0, rdp, 3'b001);
            endcase
         end
         2'b10: begin
            case (din[15:13])
               // c.slli
               3'b000: begin
                  o  = enc_i({7'b0000000, rs2}, rd, 3'b001, rd, OP_IMM);
                  ok = ~din[12];
               end
               // c.lwsp, rd of x0 is reserved
               3'b010: begin
                  o  = enc_i(imm_lwsp, 5'd2, 3'b010, rd, OP_LOAD);
                  ok = (rd != 5'd0);
               end
               3'b100: begin
                  if (rs2 != 5'd0) begin
                     // c.mv reads x0, c.add reads rd
                     o = enc_r(7'b0000000, rs2, din[12] ? rd : 5'd0, 3'b000, rd);
                  end else if (din[12] && rd == 5'd0) begin
                     o = enc_i(12'd1, 5'd0, 3'b000, 5'd0, OP_SYSTEM);
                  end else begin
                     // c.jr links to x0, c.jalr to x1
                     o  = enc_i(12'd0, rd, 3'b000, {4'b0000, din[12]}, OP_JALR);
                     ok = (rd != 5'd0);
                  end
               end
               3'b110: o = enc_s(imm_swsp, rs2, 5'd2, 3'b010);
               default: ok = 1'b0;
            endcase
         end
         // not a compressed instruction
         default: ok = 1'b0;
      endcase
   end

   assign dout  = ok ? o : '0;
   assign legal = ok;

endmodule

`default_nettype wire

/* src/ifu_pkg.sv */
//****************************
// shared types of the instruction aligner
// modules import this inside their body
//****************************

`default_nettype none

`include "ifu_cfg.svh"

package ifu_pkg;

   // one halfword of the stream or a compressed instruction
   typedef logic [15:0] inst16_t;

   // fetch word or expanded instruction
   typedef logic [31:0] inst32_t;

   typedef logic [`IFU_PC_WIDTH-1:0] pc_t;

   // halfwords held in the buffer, 0 to 4
   typedef logic [2:0] hw_cnt_t;

   typedef enum logic {
      ALIGN_RUN,
      ALIGN_SKIP
   } align_state_e;

endpackage

`default_nettype wire

/* src/ifu_cfg.svh */
//****************************
// configuration macros for the instruction aligner
// include this wherever the PC width, reset PC or buffer
// depth is needed
//****************************

`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

`define IFU_PC_WIDTH 32
`define IFU_RESET_PC 32'h0000_0000
// halfword slots in the fetch buffer
`define IFU_BUF_HW   4

`endif
